// ==== verilog/mycpu_config.svh ====
// build-time constants; translation only maps data addresses, the register count must stay 32
`ifndef MYCPU_CONFIG_SVH
`define MYCPU_CONFIG_SVH

// first instruction address after reset (kseg1 boot area)
`define MYCPU_RESET_VECTOR 32'hbfc00000

// 1 maps kseg0/kseg1 data addresses to physical, 0 passes them through
`define MYCPU_ADDR_TRANSLATE 1

// architectural register count
`define MYCPU_NUM_REGS 32

`endif

// ==== verilog/mycpu_pkg.sv ====
// shared types only; word addressing, no sub-word access fields, single-issue retire record
package mycpu_pkg;

    // 32-bit data and address word
    typedef logic [31:0] word_t;

    // general purpose register index
    typedef logic [4:0] creg_addr_t;

    // primary opcodes the core decodes, anything else retires as a no-op
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // data request from execute, held until the bus completes
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t wd;
    } mem_req_t;

    // retire record for the debug writeback port
    typedef struct packed {
        logic [3:0] wen;
        creg_addr_t wnum;
        word_t      wd;
        word_t      pc;
    } rf_w_t;

    // buffered instruction handed from fetch to execute
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_t;

endpackage

// ==== verilog/sram_handshake.sv ====
// one outstanding SRAM-like transaction; cpu_req is only sampled while idle, data_ok must follow addr_ok
`timescale 1ns/1ps

module sram_handshake (
    input  logic clk,
    input  logic arst_n,
    input  logic cpu_req,
    input  logic addr_ok,
    input  logic data_ok,
    output logic req,
    output logic done
);

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_WAIT_ADDR,
        HS_WAIT_DATA
    } hs_state_e;

    hs_state_e state;
    hs_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            HS_IDLE: begin
                if (cpu_req) begin
                    state_next = HS_WAIT_ADDR;
                end
            end
            // req stays up until the slave accepts the address
            HS_WAIT_ADDR: begin
                if (addr_ok) begin
                    state_next = HS_WAIT_DATA;
                end
            end
            HS_WAIT_DATA: begin
                if (data_ok) begin
                    state_next = HS_IDLE;
                end
            end
            default: state_next = HS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= HS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign req  = (state == HS_WAIT_ADDR);
    // completion pulse lines up with data_ok
    assign done = (state == HS_WAIT_DATA) && data_ok;

endmodule

// ==== verilog/inst_fetch.sv ====
// sequential fetch only, no branches; one-entry buffer, next fetch issues once execute has taken it
`timescale 1ns/1ps
`include "mycpu_config.svh"

module inst_fetch (
    input  logic               clk,
    input  logic               arst_n,
    input  mycpu_pkg::word_t   inst_rdata,
    input  logic               i_done,
    input  logic               take,
    output logic               fetch_req,
    output mycpu_pkg::word_t   pc,
    output mycpu_pkg::fetch_t  fetch
);

    logic             buf_valid;
    mycpu_pkg::word_t buf_pc;
    mycpu_pkg::word_t buf_instr;

    // pc is the address of the word being fetched, stable while the fetch is in flight
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `MYCPU_RESET_VECTOR;
        end else if (i_done) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_valid <= 1'b0;
        end else if (i_done) begin
            buf_valid <= 1'b1;
        end else if (take) begin
            buf_valid <= 1'b0;
        end
    end

    // buffer payload
    always_ff @(posedge clk) begin
        if (i_done) begin
            buf_pc    <= pc;
            buf_instr <= inst_rdata;
        end
    end

    // ask for the next word only while the buffer is empty
    assign fetch_req = !buf_valid;

    assign fetch.valid = buf_valid;
    assign fetch.pc    = buf_pc;
    assign fetch.instr = buf_instr;

endmodule

// ==== verilog/execute_stage.sv ====
// addiu/lui/ori/addu/lw/sw only, all else is a no-op; one instruction at a time, word loads and stores
`timescale 1ns/1ps
`include "mycpu_config.svh"

module execute_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  mycpu_pkg::fetch_t   fetch,
    output logic                take,
    output mycpu_pkg::mem_req_t mreq,
    input  mycpu_pkg::word_t    data_rdata,
    input  logic                d_done,
    output mycpu_pkg::rf_w_t    rfw
);

    localparam logic [5:0] FUNCT_ADDU = 6'h21;

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_EXEC,
        EX_MEM,
        EX_WB
    } ex_state_e;

    ex_state_e state;
    ex_state_e state_next;

    mycpu_pkg::word_t ir;
    mycpu_pkg::word_t ir_pc;
    mycpu_pkg::word_t ld_data;

    mycpu_pkg::word_t regs [`MYCPU_NUM_REGS];

    mycpu_pkg::opcode_e   op;
    mycpu_pkg::creg_addr_t rs;
    mycpu_pkg::creg_addr_t rt;
    mycpu_pkg::creg_addr_t rd;
    logic [15:0]          imm;
    logic [5:0]           funct;

    mycpu_pkg::word_t rs_val;
    mycpu_pkg::word_t rt_val;
    mycpu_pkg::word_t simm;
    mycpu_pkg::word_t alu_res;
    mycpu_pkg::creg_addr_t dest;
    logic             alu_wr;
    logic             is_mem;
    logic             is_store;
    logic             mem_active;

    logic             rf_we;
    mycpu_pkg::word_t rf_wd;

    // field split
    assign op    = mycpu_pkg::opcode_e'(ir[31:26]);
    assign rs    = ir[25:21];
    assign rt    = ir[20:16];
    assign rd    = ir[15:11];
    assign imm   = ir[15:0];
    assign funct = ir[5:0];
    assign simm  = {{16{imm[15]}}, imm};

    // r0 reads as zero whatever the array holds
    assign rs_val = (rs == 5'd0) ? '0 : regs[rs];
    assign rt_val = (rt == 5'd0) ? '0 : regs[rt];

    always_comb begin
        alu_res  = '0;
        dest     = rt;
        alu_wr   = 1'b0;
        is_mem   = 1'b0;
        is_store = 1'b0;
        case (op)
            mycpu_pkg::OP_SPECIAL: begin
                if (funct == FUNCT_ADDU) begin
                    alu_res = rs_val + rt_val;
                    dest    = rd;
                    alu_wr  = 1'b1;
                end
            end
            mycpu_pkg::OP_ADDIU: begin
                alu_res = rs_val + simm;
                alu_wr  = 1'b1;
            end
            mycpu_pkg::OP_ORI: begin
                alu_res = rs_val | {16'h0000, imm};
                alu_wr  = 1'b1;
            end
            mycpu_pkg::OP_LUI: begin
                alu_res = {imm, 16'h0000};
                alu_wr  = 1'b1;
            end
            mycpu_pkg::OP_LW: begin
                is_mem = 1'b1;
            end
            mycpu_pkg::OP_SW: begin
                is_mem   = 1'b1;
                is_store = 1'b1;
            end
            default: ;
        endcase
    end

    // sequencing
    assign take = (state == EX_IDLE) && fetch.valid;

    always_comb begin
        state_next = state;
        case (state)
            EX_IDLE: begin
                if (fetch.valid) begin
                    state_next = EX_EXEC;
                end
            end
            EX_EXEC: state_next = is_mem ? EX_MEM : EX_IDLE;
            EX_MEM: begin
                if (d_done) begin
                    state_next = EX_WB;
                end
            end
            default: state_next = EX_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= EX_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ir    <= fetch.instr;
            ir_pc <= fetch.pc;
        end
        if (d_done) begin
            ld_data <= data_rdata;
        end
    end

    // data request, stable from exec until the bus reports done
    // registers cannot change meanwhile so rs/rt values hold
    assign mem_active = (state == EX_EXEC) || (state == EX_MEM);
    assign mreq.ren   = mem_active && is_mem && !is_store;
    assign mreq.wen   = mem_active && is_store;
    assign mreq.addr  = rs_val + simm;
    assign mreq.wd    = rt_val;

    // alu results retire in exec, loads in the cycle after d_done
    assign rf_wd = (state == EX_WB) ? ld_data : alu_res;
    assign rf_we = (dest != 5'd0)
                && (((state == EX_EXEC) && alu_wr)
                ||  ((state == EX_WB) && is_mem && !is_store));

    always_ff @(posedge clk) begin
        if (rf_we) begin
            regs[dest] <= rf_wd;
        end
    end

    assign rfw.wen  = rf_we ? 4'hf : 4'h0;
    assign rfw.wnum = rf_we ? dest : '0;
    assign rfw.wd   = rf_we ? rf_wd : '0;
    assign rfw.pc   = rf_we ? ir_pc : '0;

endmodule

// ==== verilog/data_bus_adapter.sv ====
// word-size accesses only; with translation on, kseg0/kseg1 drop the top three bits, other segments pass
`timescale 1ns/1ps
`include "mycpu_config.svh"

module data_bus_adapter (
    input  mycpu_pkg::mem_req_t mreq,
    output logic                cpu_req,
    output logic                data_wr,
    output mycpu_pkg::word_t    data_addr,
    output mycpu_pkg::word_t    data_wdata,
    output logic [1:0]          data_size
);

    localparam bit ADDR_TRANSLATE = (`MYCPU_ADDR_TRANSLATE == 1);

    assign cpu_req = mreq.ren || mreq.wen;
    assign data_wr = mreq.wen;

    // write data only matters on stores
    assign data_wdata = mreq.wen ? mreq.wd : '0;

    // always a full word
    assign data_size = 2'd2;

    always_comb begin
        data_addr = mreq.addr;
        // 0x8..0xb top nibble is kseg0 or kseg1
        if (ADDR_TRANSLATE && (mreq.addr[31:30] == 2'b10)) begin
            data_addr = {3'b000, mreq.addr[28:0]};
        end
    end

endmodule

// ==== verilog/mycpu.sv ====
// no interrupts, branches or caches; instruction addresses leave untranslated, one transaction per port
`timescale 1ns/1ps

module mycpu (
    input  logic             clk,
    input  logic             arst_n,

    output logic             inst_req,
    output logic             inst_wr,
    output logic [1:0]       inst_size,
    output mycpu_pkg::word_t inst_addr,
    output mycpu_pkg::word_t inst_wdata,
    input  mycpu_pkg::word_t inst_rdata,
    input  logic             inst_addr_ok,
    input  logic             inst_data_ok,

    output logic             data_req,
    output logic             data_wr,
    output logic [1:0]       data_size,
    output mycpu_pkg::word_t data_addr,
    output mycpu_pkg::word_t data_wdata,
    input  mycpu_pkg::word_t data_rdata,
    input  logic             data_addr_ok,
    input  logic             data_data_ok,

    output mycpu_pkg::word_t      debug_wb_pc,
    output logic [3:0]            debug_wb_rf_wen,
    output mycpu_pkg::creg_addr_t debug_wb_rf_wnum,
    output mycpu_pkg::word_t      debug_wb_rf_wdata
);

    logic                fetch_req;
    logic                i_done;
    logic                take;
    logic                d_req;
    logic                d_done;
    mycpu_pkg::fetch_t   fetch;
    mycpu_pkg::mem_req_t mreq;
    mycpu_pkg::rf_w_t    rfw;

    // instruction port is read-only, full words
    assign inst_wr    = 1'b0;
    assign inst_size  = 2'd2;
    assign inst_wdata = '0;

    inst_fetch u_inst_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_rdata (inst_rdata),
        .i_done     (i_done),
        .take       (take),
        .fetch_req  (fetch_req),
        .pc         (inst_addr),
        .fetch      (fetch)
    );

    sram_handshake i_handshake (
        .clk     (clk),
        .arst_n  (arst_n),
        .cpu_req (fetch_req),
        .addr_ok (inst_addr_ok),
        .data_ok (inst_data_ok),
        .req     (inst_req),
        .done    (i_done)
    );

    execute_stage u_execute_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .fetch      (fetch),
        .take       (take),
        .mreq       (mreq),
        .data_rdata (data_rdata),
        .d_done     (d_done),
        .rfw        (rfw)
    );

    data_bus_adapter u_data_bus_adapter (
        .mreq       (mreq),
        .cpu_req    (d_req),
        .data_wr    (data_wr),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_size  (data_size)
    );

    sram_handshake d_handshake (
        .clk     (clk),
        .arst_n  (arst_n),
        .cpu_req (d_req),
        .addr_ok (data_addr_ok),
        .data_ok (data_data_ok),
        .req     (data_req),
        .done    (d_done)
    );

    assign debug_wb_pc       = rfw.pc;
    assign debug_wb_rf_wen   = rfw.wen;
    assign debug_wb_rf_wnum  = rfw.wnum;
    assign debug_wb_rf_wdata = rfw.wd;

endmodule

// ==== testbench/mycpu_checker.sv ====
// bound to mycpu; checks the SRAM-like protocol on both ports and data address translation only
`timescale 1ns/1ps
`include "mycpu_config.svh"

module mycpu_checker (
    input logic             clk,
    input logic             arst_n,
    input logic             inst_req,
    input mycpu_pkg::word_t inst_addr,
    input logic             inst_addr_ok,
    input logic             inst_data_ok,
    input logic             data_req,
    input mycpu_pkg::word_t data_addr,
    input logic             data_addr_ok,
    input logic             data_data_ok
);

    int   fail_count = 0;
    logic i_busy;
    logic d_busy;

    // address accepted, data not yet returned
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            i_busy <= 1'b0;
            d_busy <= 1'b0;
        end else begin
            if (inst_req && inst_addr_ok) begin
                i_busy <= 1'b1;
            end else if (inst_data_ok) begin
                i_busy <= 1'b0;
            end
            if (data_req && data_addr_ok) begin
                d_busy <= 1'b1;
            end else if (data_data_ok) begin
                d_busy <= 1'b0;
            end
        end
    end

    a_inst_hold: assert property (@(posedge clk) disable iff (!arst_n)
        inst_req && !inst_addr_ok |=> inst_req && $stable(inst_addr))
        else begin
            $error("inst_req dropped or inst_addr changed before addr_ok");
            fail_count++;
        end

    a_data_hold: assert property (@(posedge clk) disable iff (!arst_n)
        data_req && !data_addr_ok |=> data_req && $stable(data_addr))
        else begin
            $error("data_req dropped or data_addr changed before addr_ok");
            fail_count++;
        end

    a_inst_single: assert property (@(posedge clk) disable iff (!arst_n)
        i_busy |-> !inst_req)
        else begin
            $error("second inst_req before data_ok");
            fail_count++;
        end

    a_data_single: assert property (@(posedge clk) disable iff (!arst_n)
        d_busy |-> !data_req)
        else begin
            $error("second data_req before data_ok");
            fail_count++;
        end

    // kseg0/kseg1 must never reach the bus untranslated
    a_data_phys: assert property (@(posedge clk) disable iff (!arst_n)
        data_req && (`MYCPU_ADDR_TRANSLATE == 1) |-> data_addr[31:30] != 2'b10)
        else begin
            $error("virtual kseg0/kseg1 address on data bus");
            fail_count++;
        end

endmodule

bind mycpu mycpu_checker i_mycpu_checker (.*);

// ==== testbench/tb_mycpu.sv ====
// directed tests of mycpu; programs under 40 words, memory indexed by address bits 11:2 only
`timescale 1ns/1ps
`include "mycpu_config.svh"

module tb_mycpu;

    // 5 programs of up to 40 instructions, about 15 cycles each, plus margin
    localparam int MAX_CYCLES = 5 * 40 * 15 + 1000;

    logic clk = 1'b0;
    logic arst_n = 1'b0;
    logic inst_req, inst_wr, data_req, data_wr;
    logic [1:0] inst_size, data_size;
    mycpu_pkg::word_t inst_addr, inst_wdata, data_addr, data_wdata;
    mycpu_pkg::word_t inst_rdata = '0;
    mycpu_pkg::word_t data_rdata = '0;
    logic inst_addr_ok = 1'b0;
    logic inst_data_ok = 1'b0;
    logic data_addr_ok = 1'b0;
    logic data_data_ok = 1'b0;
    mycpu_pkg::word_t debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0] debug_wb_rf_wen;
    mycpu_pkg::creg_addr_t debug_wb_rf_wnum;

    mycpu_pkg::word_t imem [1024];
    mycpu_pkg::word_t dmem [1024];
    mycpu_pkg::word_t prog [$];
    mycpu_pkg::rf_w_t exp_q [$];
    mycpu_pkg::rf_w_t got_q [$];
    mycpu_pkg::word_t daddr_q [$];
    bit   delay_on = 1'b0;
    int   errors = 0;
    int   cycles = 0;
    string cur_test = "startup";
    logic i_ph = 1'b0;
    logic d_ph = 1'b0;
    int   i_wait = 0;
    int   d_wait = 0;
    logic [31:0] i_rnd = 32'h55441d39;
    logic [31:0] d_rnd = 32'h55441d39 ^ 32'h0f0f0f0f;
    mycpu_pkg::word_t i_addr, d_addr, d_wdata;
    logic d_wr;

    mycpu i_mycpu (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run exceeded %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // instruction port slave with an address phase and a data phase
    always @(negedge clk) begin
        if (!arst_n) begin
            inst_addr_ok = 1'b0;
            inst_data_ok = 1'b0;
            i_ph = 1'b0;
            i_wait = 0;
        end else if (!i_ph) begin
            inst_data_ok = 1'b0;
            if (inst_req && i_wait == 0) begin
                if (inst_wr !== 1'b0 || inst_size !== 2'd2 || inst_wdata !== '0) begin
                    errors++;
                    $display("FAIL %s: inst wr/size/wdata expected 0/2/%h actual %0d/%0d/%h",
                             cur_test, 32'h0, inst_wr, inst_size, inst_wdata);
                end
                inst_addr_ok = 1'b1;
                i_addr = inst_addr;
                i_ph = 1'b1;
                i_rnd = xorshift32(i_rnd);
                i_wait = delay_on ? int'(i_rnd[1:0]) : 0;
            end else if (inst_req) begin
                i_wait--;
            end
        end else begin
            inst_addr_ok = 1'b0;
            if (i_wait == 0) begin
                inst_data_ok = 1'b1;
                inst_rdata = imem[i_addr[11:2]];
                i_ph = 1'b0;
                i_rnd = xorshift32(i_rnd);
                i_wait = delay_on ? int'(i_rnd[1:0]) : 0;
            end else begin
                i_wait--;
            end
        end
    end

    // data port slave with the same timing where stores land at data_ok
    always @(negedge clk) begin
        if (!arst_n) begin
            data_addr_ok = 1'b0;
            data_data_ok = 1'b0;
            d_ph = 1'b0;
            d_wait = 0;
        end else if (!d_ph) begin
            data_data_ok = 1'b0;
            if (data_req && d_wait == 0) begin
                if (data_size !== 2'd2) begin
                    errors++;
                    $display("FAIL %s: data_size expected %0d actual %0d",
                             cur_test, 2'd2, data_size);
                end
                data_addr_ok = 1'b1;
                d_addr = data_addr;
                d_wr = data_wr;
                d_wdata = data_wdata;
                daddr_q.push_back(data_addr);
                d_ph = 1'b1;
                d_rnd = xorshift32(d_rnd);
                d_wait = delay_on ? int'(d_rnd[1:0]) : 0;
            end else if (data_req) begin
                d_wait--;
            end
        end else begin
            data_addr_ok = 1'b0;
            if (d_wait == 0) begin
                data_data_ok = 1'b1;
                if (d_wr) begin
                    dmem[d_addr[11:2]] = d_wdata;
                end
                data_rdata = d_wr ? '0 : dmem[d_addr[11:2]];
                d_ph = 1'b0;
                d_rnd = xorshift32(d_rnd);
                d_wait = delay_on ? int'(d_rnd[1:0]) : 0;
            end else begin
                d_wait--;
            end
        end
    end

    // retire monitor
    always @(negedge clk) begin
        if (arst_n && debug_wb_rf_wen != 4'h0) begin
            got_q.push_back({debug_wb_rf_wen, debug_wb_rf_wnum, debug_wb_rf_wdata, debug_wb_pc});
        end
    end

    function automatic mycpu_pkg::word_t enc_i(mycpu_pkg::opcode_e op, mycpu_pkg::creg_addr_t rs,
                                               mycpu_pkg::creg_addr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic mycpu_pkg::word_t enc_addu(mycpu_pkg::creg_addr_t rs,
                                                  mycpu_pkg::creg_addr_t rt,
                                                  mycpu_pkg::creg_addr_t rd);
        return {6'h00, rs, rt, rd, 5'd0, 6'h21};
    endfunction

    // ISA model building the expected retire records in program order
    task automatic run_reference();
        mycpu_pkg::word_t regs [32];
        mycpu_pkg::word_t rmem [1024];
        mycpu_pkg::word_t ins, pc, res, ea, simm;
        mycpu_pkg::creg_addr_t dst;
        bit wr;
        foreach (regs[r]) regs[r] = '0;
        exp_q.delete();
        pc = `MYCPU_RESET_VECTOR;
        foreach (prog[i]) begin
            ins = prog[i];
            wr = 1'b0;
            dst = ins[20:16];
            res = '0;
            simm = {{16{ins[15]}}, ins[15:0]};
            ea = regs[ins[25:21]] + simm;
            case (ins[31:26])
                mycpu_pkg::OP_LUI: begin
                    res = {ins[15:0], 16'h0000};
                    wr = 1'b1;
                end
                mycpu_pkg::OP_ORI: begin
                    res = regs[ins[25:21]] | {16'h0, ins[15:0]};
                    wr = 1'b1;
                end
                mycpu_pkg::OP_ADDIU: begin
                    res = ea;
                    wr = 1'b1;
                end
                // kseg aliases share the low address bits
                mycpu_pkg::OP_LW: begin
                    res = rmem[ea[11:2]];
                    wr = 1'b1;
                end
                mycpu_pkg::OP_SW: rmem[ea[11:2]] = regs[ins[20:16]];
                mycpu_pkg::OP_SPECIAL: begin
                    if (ins[5:0] == 6'h21) begin
                        res = regs[ins[25:21]] + regs[ins[20:16]];
                        dst = ins[15:11];
                        wr = 1'b1;
                    end
                end
                default: ;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
                exp_q.push_back({4'hf, dst, res, pc});
            end
            pc = pc + 32'd4;
        end
    endtask

    task automatic load_program();
        foreach (imem[a]) imem[a] = '0;
        foreach (prog[i]) imem[i] = prog[i];
        run_reference();
    endtask

    task automatic apply_reset();
        @(negedge clk);
        arst_n = 1'b0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
    endtask

    // waits for the expected record count, then compares in order
    task automatic check_records(string name, int base);
        mycpu_pkg::rf_w_t got;
        while (got_q.size() < base + exp_q.size()) @(negedge clk);
        repeat (30) @(negedge clk);
        if (got_q.size() != base + exp_q.size()) begin
            errors++;
            $display("FAIL %s: record count expected %0d actual %0d", name, exp_q.size(),
                     got_q.size() - base);
        end
        foreach (exp_q[i]) begin
            got = got_q[base + i];
            if (got != exp_q[i]) begin
                errors++;
                $display("FAIL %s: record %0d expected %h actual %h", name, i, exp_q[i], got);
            end
        end
    endtask

    task automatic alu_program();
        prog.delete();
        prog.push_back(enc_i(mycpu_pkg::OP_LUI, 5'd0, 5'd1, 16'h1234));
        prog.push_back(enc_i(mycpu_pkg::OP_ORI, 5'd1, 5'd1, 16'h5678));
        prog.push_back(enc_i(mycpu_pkg::OP_ADDIU, 5'd0, 5'd2, 16'hffff));
        prog.push_back(enc_addu(5'd1, 5'd2, 5'd3));
        prog.push_back(enc_i(mycpu_pkg::OP_ADDIU, 5'd3, 5'd4, 16'h0010));
        prog.push_back(enc_i(mycpu_pkg::OP_ORI, 5'd0, 5'd5, 16'h00ff));
        prog.push_back(enc_addu(5'd5, 5'd4, 5'd6));
        load_program();
    endtask

    task automatic test_alu();
        int base;
        cur_test = "test_alu";
        delay_on = 1'b0;
        alu_program();
        base = got_q.size();
        apply_reset();
        check_records("test_alu", base);
    endtask

    task automatic test_backpressure();
        int base;
        cur_test = "test_backpressure";
        delay_on = 1'b1;
        alu_program();
        base = got_q.size();
        apply_reset();
        check_records("test_backpressure", base);
    endtask

    task automatic test_load_store();
        int base;
        int abase;
        cur_test = "test_load_store";
        delay_on = 1'b1;
        prog.delete();
        prog.push_back(enc_i(mycpu_pkg::OP_LUI, 5'd0, 5'd1, 16'ha000));
        prog.push_back(enc_i(mycpu_pkg::OP_ORI, 5'd1, 5'd1, 16'h0100));
        prog.push_back(enc_i(mycpu_pkg::OP_LUI, 5'd0, 5'd2, 16'hcafe));
        prog.push_back(enc_i(mycpu_pkg::OP_ORI, 5'd2, 5'd2, 16'hbeef));
        prog.push_back(enc_i(mycpu_pkg::OP_SW, 5'd1, 5'd2, 16'h0000));
        prog.push_back(enc_i(mycpu_pkg::OP_LUI, 5'd0, 5'd3, 16'h8000));
        prog.push_back(enc_i(mycpu_pkg::OP_ORI, 5'd3, 5'd3, 16'h0100));
        prog.push_back(enc_i(mycpu_pkg::OP_LW, 5'd3, 5'd4, 16'h0000));
        prog.push_back(enc_addu(5'd4, 5'd0, 5'd5));
        load_program();
        base = got_q.size();
        abase = daddr_q.size();
        apply_reset();
        check_records("test_load_store", base);
        if (daddr_q.size() != abase + 2) begin
            errors++;
            $display("FAIL test_load_store: data requests expected 2 actual %0d",
                     daddr_q.size() - abase);
        end
        for (int i = abase; i < daddr_q.size(); i++) begin
            if (daddr_q[i] != 32'h0000_0100) begin
                errors++;
                $display("FAIL test_load_store: data_addr expected %h actual %h",
                         32'h0000_0100, daddr_q[i]);
            end
        end
        if (dmem[64] != 32'hcafebeef) begin
            errors++;
            $display("FAIL test_load_store: stored word expected %h actual %h",
                     32'hcafebeef, dmem[64]);
        end
    endtask

    task automatic test_reg_zero();
        int base;
        cur_test = "test_reg_zero";
        delay_on = 1'b0;
        prog.delete();
        prog.push_back(enc_i(mycpu_pkg::OP_ADDIU, 5'd0, 5'd0, 16'h0005));
        prog.push_back(enc_i(mycpu_pkg::OP_LUI, 5'd0, 5'd0, 16'h7777));
        prog.push_back(enc_i(mycpu_pkg::OP_ADDIU, 5'd0, 5'd1, 16'h0003));
        prog.push_back(enc_addu(5'd0, 5'd0, 5'd2));
        prog.push_back(enc_i(mycpu_pkg::OP_ORI, 5'd1, 5'd0, 16'h0001));
        prog.push_back(enc_addu(5'd1, 5'd0, 5'd3));
        load_program();
        base = got_q.size();
        apply_reset();
        check_records("test_reg_zero", base);
    endtask

    task automatic check_idle_outputs();
        if (inst_req || data_req || debug_wb_rf_wen != 4'h0) begin
            errors++;
            $display("test_reset: bus request or writeback active around reset");
        end
    endtask

    task automatic test_reset();
        int base;
        cur_test = "test_reset";
        delay_on = 1'b1;
        alu_program();
        base = got_q.size();
        apply_reset();
        while (got_q.size() < base + 2) @(negedge clk);
        // pull reset in the middle of the program
        arst_n = 1'b0;
        repeat (16) begin
            @(negedge clk);
            check_idle_outputs();
        end
        base = got_q.size();
        arst_n = 1'b1;
        @(negedge clk);
        // one edge after release only the fetch request is up
        if (data_req || debug_wb_rf_wen != 4'h0) begin
            errors++;
            $display("test_reset: data request or writeback active after reset release");
        end
        if (!inst_req) begin
            errors++;
            $display("test_reset: no instruction request on the first edge after release");
        end else if (inst_addr != `MYCPU_RESET_VECTOR) begin
            errors++;
            $display("FAIL test_reset: first inst_addr expected %h actual %h",
                     `MYCPU_RESET_VECTOR, inst_addr);
        end
        check_records("test_reset", base);
    endtask

    initial begin
        test_alu();
        test_backpressure();
        test_load_store();
        test_reg_zero();
        test_reset();
        errors += i_mycpu.i_mycpu_checker.fail_count;
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== mycpu.f ====
+incdir+verilog
verilog/mycpu_pkg.sv
verilog/sram_handshake.sv
verilog/inst_fetch.sv
verilog/execute_stage.sv
verilog/data_bus_adapter.sv
verilog/mycpu.sv
testbench/mycpu_checker.sv
testbench/tb_mycpu.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mycpu -f mycpu.f -o tb_mycpu_sim \
    && ./obj_dir/tb_mycpu_sim | grep -q "TEST PASSED" \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
